// ==== source/fetch_consts.svh ====
// Fixed RV32 fetch constants; queue logic assumes 16-bit parcels and a depth of at most 15
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////
// Widths and sizes
`define FETCH_XLEN           32
`define FETCH_PARCEL_W       16
`define FETCH_PC_INIT        32'h0000_0200
`define FETCH_QUEUE_DEPTH    8
`define FETCH_FULL_THRESHOLD 4              // Leaves room for one outstanding plus one returning word

// addi x0,x0,0
`define FETCH_NOP            32'h0000_0013

////////////////////
// RV32 opcodes and functs
`define FETCH_OPC_OP_IMM     7'b0010011
`define FETCH_OPC_OP         7'b0110011
`define FETCH_OPC_JALR       7'b1100111
`define FETCH_F3_ADD         3'b000
`define FETCH_F7_ADD         7'b0000000

// RVC quadrants and functs of the supported subset
`define FETCH_RVC_Q1         2'b01
`define FETCH_RVC_Q2         2'b10
`define FETCH_RVC_F3_ADDI    3'b000
`define FETCH_RVC_F3_LI      3'b010
`define FETCH_RVC_F4_JR_MV   4'b1000
`define FETCH_RVC_F4_ADD     4'b1001

`endif

// ==== source/fetch_pkg.sv ====
// Parcel decode types for RV32C only; field names follow the CI and CR formats of the spec
package fetch_pkg;

  ////////////////////
  // CI format, used by C.ADDI and C.LI
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm5;     // Sign bit of the immediate
    logic [4:0] rd;       // Also rs1 for C.ADDI
    logic [4:0] imm;      // imm[4:0]
    logic [1:0] op;
  } rvc_ci_t;

  ////////////////////
  // CR format, used by C.MV, C.ADD and C.JR
  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd;       // rs1 for C.JR
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_cr_t;

  // One parcel, two views
  // C.ADDI/C.LI decode it as CI while C.MV/C.ADD/C.JR decode it as CR
  typedef union packed {
    rvc_ci_t ci;
    rvc_cr_t cr;
  } rvc_parcel_t;

endpackage

// ==== source/parcel_if.sv ====
// Queue to aligner link; pop must never exceed head_cnt and acts on the next clock edge
`timescale 1ns/1ps
`include "fetch_consts.svh"

interface parcel_if;

  logic [2*`FETCH_PARCEL_W-1:0] head;        // Two oldest parcels, oldest in the low half
  logic [1:0]                   head_cnt;    // Valid parcels at head, 0 to 2
  logic [1:0]                   head_fault;  // Access fault per head parcel
  logic [1:0]                   pop;         // Parcels consumed this cycle

  modport queue (
    output head,
    output head_cnt,
    output head_fault,
    input  pop
  );

  modport align (
    input  head,
    input  head_cnt,
    input  head_fault,
    output pop
  );

endinterface

// ==== source/fetch_addr_gen.sv ====
// Word-aligned linear fetch; memory must drop outstanding responses when imem_flush_o pulses
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_addr_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic [3:0]            queue_cnt_i,
  input  logic                  imem_ack_i,
  output logic                  imem_req_o,
  output logic [`FETCH_XLEN-1:0] imem_adr_o,
  output logic                  imem_flush_o
);

  logic run_q;     // Fetch enable, set one cycle after reset
  logic accept;

  ////////////////////
  // Request and flush

  // Stop asking once the queue reaches the threshold
  assign imem_req_o   = run_q & (queue_cnt_i < `FETCH_FULL_THRESHOLD) & ~redirect_i;
  assign imem_flush_o = redirect_i;
  assign accept       = imem_req_o & imem_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      run_q <= 1'b0;
    else
      run_q <= 1'b1;
  end

  ////////////////////
  // Address counter
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      imem_adr_o <= `FETCH_PC_INIT & ~32'h3;
    else if (redirect_i)
      imem_adr_o <= {redirect_pc_i[`FETCH_XLEN-1:2], 2'b00};  // Half-word target fetches whole word
    else if (accept)
      imem_adr_o <= imem_adr_o + 32'd4;
  end

endmodule

// ==== source/parcel_queue.sv ====
// In-order parcel shift queue; relies on the request threshold to never push past its depth
`timescale 1ns/1ps
`include "fetch_consts.svh"

module parcel_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   flush_half_i,   // Target bit 1, only sampled with flush_i
  input  logic                   imem_valid_i,
  input  logic [`FETCH_XLEN-1:0] imem_word_i,
  input  logic                   imem_fault_i,
  output logic [3:0]             cnt_o,
  parcel_if.queue                pq
);

  logic [`FETCH_PARCEL_W-1:0]    par_q [`FETCH_QUEUE_DEPTH];
  logic [`FETCH_PARCEL_W-1:0]    par_n [`FETCH_QUEUE_DEPTH];
  logic [`FETCH_QUEUE_DEPTH-1:0] fault_q;
  logic [`FETCH_QUEUE_DEPTH-1:0] fault_n;
  logic [3:0]                    cnt_q;
  logic [3:0]                    cnt_n;
  logic [3:0]                    cnt_pop;        // Count left after the pop
  logic                          skip_q;         // Drop low half of next word
  logic                          push;
  logic                          push_lo;

  assign push    = imem_valid_i & ~flush_i;     // Responses in the flush cycle are stale
  assign push_lo = push & ~skip_q;
  assign cnt_pop = cnt_q - {2'b00, pq.pop};

  ////////////////////
  // Shift and push
  always_comb
  begin
    for (int i = 0; i < `FETCH_QUEUE_DEPTH; i++)
    begin
      if (i + int'(pq.pop) < `FETCH_QUEUE_DEPTH)
      begin
        par_n[i]   = par_q[i + int'(pq.pop)];
        fault_n[i] = fault_q[i + int'(pq.pop)];
      end
      else
      begin
        par_n[i]   = '0;
        fault_n[i] = 1'b0;
      end

      // New parcels land right behind the survivors
      if (push_lo && i == int'(cnt_pop))
      begin
        par_n[i]   = imem_word_i[`FETCH_PARCEL_W-1:0];
        fault_n[i] = imem_fault_i;
      end
      if (push && i == int'(cnt_pop + {3'b000, push_lo}))
      begin
        par_n[i]   = imem_word_i[`FETCH_XLEN-1:`FETCH_PARCEL_W];
        fault_n[i] = imem_fault_i;
      end
    end

    if (flush_i)
      cnt_n = 4'd0;
    else
      cnt_n = cnt_pop + (push_lo ? 4'd2 : {3'b000, push});
  end

  always_ff @(posedge clk_i)
  begin
    par_q   <= par_n;
    fault_q <= fault_n;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cnt_q  <= 4'd0;
      skip_q <= 1'b0;
    end
    else
    begin
      cnt_q <= cnt_n;
      if (flush_i)
        skip_q <= flush_half_i;
      else if (push)
        skip_q <= 1'b0;         // Only the first word after redirect
    end
  end

  ////////////////////
  // Head view
  assign pq.head       = {par_q[1], par_q[0]};
  assign pq.head_fault = {fault_q[1], fault_q[0]};
  assign pq.head_cnt   = (cnt_q > 4'd1) ? 2'd2 : cnt_q[1:0];
  assign cnt_o         = cnt_q;

endmodule

// ==== source/insn_align.sv ====
// Length decode for 16/32-bit only; a redirect wins over stall and drops the held output
`timescale 1ns/1ps
`include "fetch_consts.svh"

module insn_align (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   stall_i,
  parcel_if.align                pq,
  input  logic [`FETCH_XLEN-1:0] exp_insn_i,
  input  logic                   exp_illegal_i,
  output fetch_pkg::rvc_parcel_t rvc_o,
  output logic [`FETCH_XLEN-1:0] insn_o,
  output logic [`FETCH_XLEN-1:0] pc_o,
  output logic                   valid_o,
  output logic                   illegal_o,
  output logic                   fault_o
);

  import fetch_pkg::*;

  logic [`FETCH_PARCEL_W-1:0] lo;
  logic                       is_rvc;
  logic                       avail;      // Whole instruction at head
  logic                       issue;
  logic [`FETCH_XLEN-1:0]     nxt_pc_q;
  logic [`FETCH_XLEN-1:0]     insn_d;

  assign lo     = pq.head[`FETCH_PARCEL_W-1:0];
  assign is_rvc = (lo[1:0] != 2'b11);
  assign avail  = is_rvc ? (pq.head_cnt != 2'd0) : (pq.head_cnt == 2'd2);
  assign issue  = avail & ~stall_i & ~redirect_i;

  assign pq.pop = !issue ? 2'd0 : (is_rvc ? 2'd1 : 2'd2);
  assign rvc_o  = rvc_parcel_t'(lo);              // Expander sees the low parcel
  assign insn_d = is_rvc ? exp_insn_i : pq.head;

  ////////////////////
  // Next PC
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      nxt_pc_q <= `FETCH_PC_INIT;
    else if (redirect_i)
      nxt_pc_q <= {redirect_pc_i[`FETCH_XLEN-1:1], 1'b0};
    else if (issue)
      nxt_pc_q <= nxt_pc_q + (is_rvc ? 32'd2 : 32'd4);
  end

  ////////////////////
  // Output stage
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_o   <= 1'b0;
      insn_o    <= `FETCH_NOP;
      pc_o      <= `FETCH_PC_INIT;
      illegal_o <= 1'b0;
      fault_o   <= 1'b0;
    end
    else if (redirect_i)
      valid_o <= 1'b0;
    else if (!stall_i)
    begin
      valid_o <= avail;
      if (avail)
      begin
        insn_o    <= insn_d;
        pc_o      <= nxt_pc_q;
        illegal_o <= is_rvc & exp_illegal_i;
        fault_o   <= is_rvc ? pq.head_fault[0] : |pq.head_fault;  // Either half faulting
      end
    end
  end

endmodule

// ==== source/rvc_expand.sv ====
// Expands only C.NOP/C.ADDI, C.LI, C.MV, C.ADD and C.JR; all else returns the parcel as illegal
`timescale 1ns/1ps
`include "fetch_consts.svh"

module rvc_expand (
  input  fetch_pkg::rvc_parcel_t rvc_i,
  output logic [`FETCH_XLEN-1:0] insn_o,
  output logic                   illegal_o
);

  import fetch_pkg::*;

  rvc_ci_t     ci;
  rvc_cr_t     cr;
  logic [11:0] imm_ci;       // Sign-extended CI immediate

  assign ci     = rvc_i.ci;
  assign cr     = rvc_i.cr;
  assign imm_ci = {{7{ci.imm5}}, ci.imm};

  always_comb
  begin
    insn_o    = {16'h0000, rvc_i};   // Unsupported or reserved
    illegal_o = 1'b1;

    if (ci.op == `FETCH_RVC_Q1 && ci.funct3 == `FETCH_RVC_F3_ADDI)
    begin
      illegal_o = 1'b0;
      if (ci.rd == 5'd0)
        insn_o = `FETCH_NOP;         // C.NOP and its hints
      else
        insn_o = {imm_ci, ci.rd, `FETCH_F3_ADD, ci.rd, `FETCH_OPC_OP_IMM};
    end
    else if (ci.op == `FETCH_RVC_Q1 && ci.funct3 == `FETCH_RVC_F3_LI)
    begin
      illegal_o = 1'b0;
      insn_o    = {imm_ci, 5'd0, `FETCH_F3_ADD, ci.rd, `FETCH_OPC_OP_IMM};  // addi rd,x0,imm
    end
    else if (cr.op == `FETCH_RVC_Q2 && cr.funct4 == `FETCH_RVC_F4_JR_MV)
    begin
      if (cr.rs2 != 5'd0)
      begin
        // C.MV is add rd,x0,rs2
        illegal_o = 1'b0;
        insn_o    = {`FETCH_F7_ADD, cr.rs2, 5'd0, `FETCH_F3_ADD, cr.rd, `FETCH_OPC_OP};
      end
      else if (cr.rd != 5'd0)
      begin
        illegal_o = 1'b0;
        insn_o    = {12'd0, cr.rd, 3'b000, 5'd0, `FETCH_OPC_JALR};  // jalr x0,0(rd)
      end
    end
    else if (cr.op == `FETCH_RVC_Q2 && cr.funct4 == `FETCH_RVC_F4_ADD && cr.rs2 != 5'd0)
    begin
      // C.ADD only, C.JALR and C.EBREAK are not supported
      illegal_o = 1'b0;
      insn_o    = {`FETCH_F7_ADD, cr.rs2, cr.rd, `FETCH_F3_ADD, cr.rd, `FETCH_OPC_OP};
    end
  end

endmodule

// ==== source/fetch_top.sv ====
// RV32 fetch front end; memory returns words in order with at least one cycle of latency
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  output logic [`FETCH_XLEN-1:0] imem_adr_o,
  output logic                   imem_req_o,
  input  logic                   imem_ack_i,
  output logic                   imem_flush_o,
  input  logic                   imem_valid_i,
  input  logic [`FETCH_XLEN-1:0] imem_word_i,
  input  logic                   imem_fault_i,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   stall_i,
  output logic [`FETCH_XLEN-1:0] insn_o,
  output logic [`FETCH_XLEN-1:0] pc_o,
  output logic                   valid_o,
  output logic                   illegal_o,
  output logic                   fault_o
);

  import fetch_pkg::*;

  logic [3:0]             queue_cnt;
  rvc_parcel_t            rvc;
  logic [`FETCH_XLEN-1:0] exp_insn;
  logic                   exp_illegal;

  parcel_if pq_if ();

  ////////////////////
  // Memory side
  fetch_addr_gen u_addr_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .queue_cnt_i   (queue_cnt),
    .imem_ack_i    (imem_ack_i),
    .imem_req_o    (imem_req_o),
    .imem_adr_o    (imem_adr_o),
    .imem_flush_o  (imem_flush_o)
  );

  parcel_queue u_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (imem_flush_o),
    .flush_half_i (redirect_pc_i[1]),   // Skip low parcel for half-word targets
    .imem_valid_i (imem_valid_i),
    .imem_word_i  (imem_word_i),
    .imem_fault_i (imem_fault_i),
    .cnt_o        (queue_cnt),
    .pq           (pq_if.queue)
  );

  ////////////////////
  // Instruction side
  insn_align u_align (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .pq            (pq_if.align),
    .exp_insn_i    (exp_insn),
    .exp_illegal_i (exp_illegal),
    .rvc_o         (rvc),
    .insn_o        (insn_o),
    .pc_o          (pc_o),
    .valid_o       (valid_o),
    .illegal_o     (illegal_o),
    .fault_o       (fault_o)
  );

  rvc_expand u_expand (
    .rvc_i     (rvc),
    .insn_o    (exp_insn),
    .illegal_o (exp_illegal)
  );

endmodule

// ==== sim/fetch_checker.sv ====
// Bound to fetch_top; assumes stall_i and redirect_i change only between rising clock edges
`timescale 1ns/1ps

module fetch_checker (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        stall_i,
  input logic        redirect_i,
  input logic        imem_valid_i,
  input logic        imem_req_o,
  input logic        imem_flush_o,
  input logic [31:0] insn_o,
  input logic [31:0] pc_o,
  input logic        valid_o,
  input logic        illegal_o,
  input logic        fault_o
);

  logic resp_seen_q;   // Set by the first returned word

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      resp_seen_q <= 1'b0;
    else if (imem_valid_i)
      resp_seen_q <= 1'b1;
  end

  ////////////////////
  // Properties
  valid_after_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !resp_seen_q |-> !valid_o)
    else $error("valid_o high before any memory response");

  hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_i && !redirect_i) |=> $stable({insn_o, pc_o, valid_o, illegal_o, fault_o}))
    else $error("outputs changed while stalled");

  no_req_on_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_flush_o |-> !imem_req_o)
    else $error("request raised during flush");

endmodule

// ==== sim/fetch_tb.sv ====
// Memory model keeps one request outstanding and wraps addresses at 2 KiB; one test per region
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;

  localparam int          NUM_TESTS = 6;
  localparam logic [31:0] FLT_LO    = 32'h0000_0600;   // Faulting word range
  localparam logic [31:0] FLT_HI    = 32'h0000_0640;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [31:0] imem_adr_o;
  logic        imem_req_o;
  logic        imem_ack_i;
  logic        imem_flush_o;
  logic        imem_valid_i;
  logic [31:0] imem_word_i;
  logic        imem_fault_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic        stall_i;
  logic [31:0] insn_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        illegal_o;
  logic        fault_o;

  logic [15:0] prog [0:1023];        // Parcels by byte address / 2
  integer      seed = 23;
  integer      cyc = 0;
  logic [31:0] pend_adr [$];
  integer      pend_due [$];
  logic        redir_pend = 1'b0;
  logic [31:0] redir_pc = '0;
  logic        stall_en = 1'b0;
  integer      stall_left = 0;
  string       cur_test = "reset";
  integer      err_cnt = 0;
  integer      n_checked = 0;
  integer      n_rvc = 0;
  integer      n_ill = 0;
  integer      n_flt = 0;
  logic [31:0] exp_pc;

  fetch_top u_fetch_top (.*);

  bind fetch_top fetch_checker u_checker (.*);

  always #4 clk_i = ~clk_i;

  ////////////////////
  // Program model
  function automatic logic [15:0] parcel_at(input logic [31:0] a);
    return prog[a[10:1]];
  endfunction

  function automatic logic word_faults(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return (w >= FLT_LO) && (w < FLT_HI);
  endfunction

  // Expected instruction at pc, from the RVC subset rules
  function automatic logic [31:0] expand_ref(input logic [31:0] pc, output logic ill,
                                             output logic flt, output logic [31:0] len);
    logic [15:0] p;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] res;
    p   = parcel_at(pc);
    rd  = p[11:7];
    rs2 = p[6:2];
    imm = {{7{p[12]}}, p[6:2]};
    ill = 1'b0;
    len = 32'd2;
    flt = word_faults(pc);
    res = {16'h0000, p};
    if (p[1:0] == 2'b11)
    begin
      len = 32'd4;
      flt = flt | word_faults(pc + 32'd2);   // Straddling word may fault
      res = {parcel_at(pc + 32'd2), p};
    end
    else if (p[1:0] == 2'b01 && p[15:13] == 3'b000)
      res = (rd == 5'd0) ? 32'h0000_0013 : {imm, rd, 3'b000, rd, 7'b0010011};
    else if (p[1:0] == 2'b01 && p[15:13] == 3'b010)
      res = {imm, 5'd0, 3'b000, rd, 7'b0010011};
    else if (p[1:0] == 2'b10 && p[15:12] == 4'b1000 && rs2 != 5'd0)
      res = {7'd0, rs2, 5'd0, 3'b000, rd, 7'b0110011};
    else if (p[1:0] == 2'b10 && p[15:12] == 4'b1000 && rd != 5'd0)
      res = {12'd0, rd, 3'b000, 5'd0, 7'b1100111};
    else if (p[1:0] == 2'b10 && p[15:12] == 4'b1001 && rs2 != 5'd0)
      res = {7'd0, rs2, rd, 3'b000, rd, 7'b0110011};
    else
      ill = 1'b1;
    return res;
  endfunction

  function automatic logic [15:0] rand_rvc(input logic [31:0] r);
    case (r[31:29] % 5)
      0:       return {3'b000, r[12], r[11:7], r[6:2], 2'b01};     // C.ADDI
      1:       return {3'b010, r[12], r[11:7], r[6:2], 2'b01};     // C.LI
      2:       return {4'b1000, r[11:7], r[6:3], 1'b1, 2'b10};     // C.MV
      3:       return {4'b1001, r[11:7], r[6:3], 1'b1, 2'b10};     // C.ADD
      default: return {4'b1000, r[11:8], 1'b1, 5'd0, 2'b10};       // C.JR
    endcase
  endfunction

  function automatic logic [15:0] rand_bad(input logic [31:0] r);
    case (r[31:30])
      2'd0:    return 16'h8002;                                    // C.JR x0 is reserved
      2'd1:    return {3'b100, r[12:2], 2'b01};
      default: return {r[15:2], 2'b00};                            // Quadrant 0
    endcase
  endfunction

  task automatic fill_program();
    integer i;
    logic [31:0] r;
    for (i = 0; i < 1024; i++)
      prog[i] = (i * 16'h9E37) ^ 16'h5A5A ^ (i >> 3);
    for (i = 'h100; i < 'h120; i += 2)
    begin
      r = $random(seed);
      prog[i]     = {r[15:2], 2'b11};
      prog[i + 1] = r[31:16];
    end
    i = 'h120;
    while (i < 'h180)
    begin
      r = $random(seed);
      if (r[0] && i < 'h17F)
      begin
        prog[i]     = {r[15:2], 2'b11};
        prog[i + 1] = r[31:16] ^ r[15:0];
        i += 2;
      end
      else
      begin
        prog[i] = rand_rvc($random(seed));
        i += 1;
      end
    end
    for (i = 'h180; i < 'h1C0; i++)
      prog[i] = rand_bad($random(seed));
  endtask

  task automatic fail_stop(input string what);
    err_cnt++;
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  ////////////////////
  // One cycle of stimulus, driven on the falling edge
  task automatic step();
    logic [31:0] a;
    @(negedge clk_i);
    cyc++;
    redirect_i = redir_pend;
    if (redir_pend)
      redirect_pc_i = redir_pc;
    redir_pend   = 1'b0;
    imem_valid_i = 1'b0;
    if (pend_adr.size() != 0 && pend_due[0] <= cyc)
    begin
      a            = pend_adr.pop_front();
      void'(pend_due.pop_front());
      imem_valid_i = 1'b1;
      imem_word_i  = {prog[{a[10:2], 1'b1}], prog[{a[10:2], 1'b0}]};
      imem_fault_i = word_faults(a);
    end
    if (!stall_en)
      stall_left = 0;
    else if (stall_left > 0)
      stall_left--;
    else if (($random(seed) & 7) == 0)
      stall_left = 1 + ($unsigned($random(seed)) % 4);
    stall_i    = (stall_left > 0);
    imem_ack_i = (($random(seed) & 3) != 0) && (pend_adr.size() == 0);
    #1;
    if (imem_flush_o)
    begin
      pend_adr.delete();     // Words still in flight are lost
      pend_due.delete();
    end
    else if (imem_req_o && imem_ack_i)
    begin
      pend_adr.push_back(imem_adr_o);
      pend_due.push_back(cyc + 1 + ($unsigned($random(seed)) % 3));
    end
  endtask

  task automatic run_test(input string name, input logic redir, input logic [31:0] target,
                          input integer count, input logic stalls);
    integer goal;
    cur_test   = name;
    stall_en   = stalls;
    redir_pend = redir;
    redir_pc   = target;
    if (redir)
      step();             // Redirect cycle, the old stream ends here
    goal = n_checked + count;
    while (n_checked < goal)
      step();
  endtask

  ////////////////////
  // Comparison against the reference
  always @(posedge clk_i)
  begin : compare
    logic [31:0] e_insn;
    logic [31:0] e_len;
    logic        e_ill;
    logic        e_flt;
    if (!rst_ni)
      exp_pc = `FETCH_PC_INIT;
    else if (redirect_i)
      exp_pc = redirect_pc_i;
    else if (valid_o && !stall_i)
    begin
      e_insn = expand_ref(exp_pc, e_ill, e_flt, e_len);
      assert (pc_o == exp_pc)
        else fail_stop($sformatf("mismatch %s pc expected %h actual %h", cur_test, exp_pc, pc_o));
      assert (insn_o == e_insn)
        else fail_stop($sformatf("mismatch %s insn expected %h actual %h",
                                 cur_test, e_insn, insn_o));
      assert (illegal_o == e_ill)
        else fail_stop($sformatf("mismatch %s illegal expected %b actual %b",
                                 cur_test, e_ill, illegal_o));
      assert (fault_o == e_flt)
        else fail_stop($sformatf("mismatch %s fault expected %b actual %b",
                                 cur_test, e_flt, fault_o));
      n_rvc     += (e_len == 32'd2 && !e_ill) ? 1 : 0;
      n_ill     += e_ill ? 1 : 0;
      n_flt     += e_flt ? 1 : 0;
      exp_pc     = exp_pc + e_len;
      n_checked += 1;
    end
  end

  // Watchdog, 200 cycles per test
  initial
  begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("Timeout in test %s after %0d cycles", cur_test, NUM_TESTS * 200);
    $display("Done: errors found");
    $fatal(1);
  end

  initial
  begin : main
    integer mark;
    rst_ni        = 1'b0;
    imem_ack_i    = 1'b0;
    imem_valid_i  = 1'b0;
    imem_word_i   = '0;
    imem_fault_i  = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    fill_program();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    run_test("linear32", 1'b0, '0, 16, 1'b0);
    mark = n_rvc;
    run_test("mixed", 1'b1, 32'h0000_0240, 40, 1'b0);
    assert (n_rvc > mark)
      else fail_stop("no compressed instruction was expanded in the mixed stream");
    mark = n_ill;
    run_test("illegal_rvc", 1'b1, 32'h0000_0300, 32, 1'b0);
    assert (n_ill > mark)
      else fail_stop("no illegal compressed instruction was seen");
    run_test("redirect_half", 1'b1, 32'h0000_0402, 20, 1'b0);
    run_test("stall_bursts", 1'b1, 32'h0000_0240, 40, 1'b1);
    mark = n_flt;
    run_test("fault_range", 1'b1, 32'h0000_05F8, 30, 1'b0);
    assert (n_flt > mark)
      else fail_stop("no faulting instruction was seen in the marked range");

    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+source
source/fetch_pkg.sv
source/parcel_if.sv
source/fetch_addr_gen.sv
source/parcel_queue.sv
source/insn_align.sv
source/rvc_expand.sv
source/fetch_top.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
